// ==== raybox_defs.svh ====
/*
  Shared constants for the raybox display pipeline.
  Screen timing, the fixed-point format, map overlay geometry,
  SPI frame length and the player start position.
  Include in any file that needs one of these values.
*/
`ifndef RAYBOX_DEFS_SVH
`define RAYBOX_DEFS_SVH

// Horizontal timing in pixels
`define RB_H_VISIBLE        640
`define RB_H_SYNC_START     656
`define RB_H_SYNC_END       752
`define RB_H_TOTAL          800

// Vertical timing in lines
`define RB_V_VISIBLE        480
`define RB_V_SYNC_START     490
`define RB_V_SYNC_END       492
`define RB_V_TOTAL          525

// Ceiling above this line, floor from here down
`define RB_HALF_HEIGHT      240

// Q12.12 signed fixed point
`define RB_QM               12
`define RB_QN               12
`define RB_QMN              (`RB_QM + `RB_QN)

// 64x64 cell map, each cell drawn as 4x4 pixels plus a closing grid line
`define RB_MAP_SIZE_BITS    6
`define RB_MAP_SCALE        2
`define RB_MAP_OVERLAY_SIZE ((1 << (`RB_MAP_SCALE + `RB_MAP_SIZE_BITS)) + 1)

// playerX then playerY, 24 bits each
`define RB_SPI_FRAME_BITS   48

// Scan point where the position register takes the latest SPI frame
`define RB_LOAD_H           799
`define RB_LOAD_V           478

// Start position 32.5, 39.5 as raw Q12.12 words
`define RB_PLAYER_X_START   24'sh020800
`define RB_PLAYER_Y_START   24'sh027800

`endif

// ==== raybox_pkg.sv ====
/*
  Common types for the raybox display pipeline.
  Referenced with scoped names, e.g. raybox_pkg::fixed_t.
  Widths come from the shared defines header.
*/
`include "raybox_defs.svh"

package raybox_pkg;

    // Player coordinate in Q12.12
    // Integer part in the top 12 bits, fraction in the low 12
    typedef logic signed [`RB_QMN-1:0] fixed_t;

    // Scan counter value
    // Wide enough for 0..799 horizontally and 0..524 vertically
    typedef logic [9:0] scan_t;

    // One colour channel, 2 bits per colour gives 64 colours in total
    typedef logic [1:0] channel_t;

    // Map cell contents
    // 0 is empty floor, nonzero values are wall types
    typedef logic [1:0] map_val_t;

    // Map cell index along one axis, 0..63
    typedef logic [`RB_MAP_SIZE_BITS-1:0] map_coord_t;

endpackage

// ==== vga_timing.sv ====
/*
  640x480 VGA scan generator.
  Advances one pixel per clock over an 800x525 frame and decodes
  sync, visible area and the per-frame position load point.
  Outputs are combinational from the counters.
*/
`include "raybox_defs.svh"

module vga_timing (
    input  logic              clk,
    input  logic              reset,
    output raybox_pkg::scan_t o_scan_h,
    output raybox_pkg::scan_t o_scan_v,
    output logic              o_hsync,
    output logic              o_vsync,
    output logic              o_visible,
    output logic              o_load_point
);

    raybox_pkg::scan_t h;
    raybox_pkg::scan_t v;

    logic h_last;
    logic v_last;

    assign h_last = (h == raybox_pkg::scan_t'(`RB_H_TOTAL - 1));
    assign v_last = (v == raybox_pkg::scan_t'(`RB_V_TOTAL - 1));

    // Line counter steps only when the pixel counter wraps
    always_ff @(posedge clk) begin
        if (reset) begin
            h <= '0;
            v <= '0;
        end else if (h_last) begin
            h <= '0;
            v <= v_last ? '0 : v + 1'b1;
        end else begin
            h <= h + 1'b1;
        end
    end

    assign o_scan_h = h;
    assign o_scan_v = v;

    // Both sync pulses are active low
    assign o_hsync = ~((h >= raybox_pkg::scan_t'(`RB_H_SYNC_START)) &&
                       (h <  raybox_pkg::scan_t'(`RB_H_SYNC_END)));
    assign o_vsync = ~((v >= raybox_pkg::scan_t'(`RB_V_SYNC_START)) &&
                       (v <  raybox_pkg::scan_t'(`RB_V_SYNC_END)));

    assign o_visible = (h < raybox_pkg::scan_t'(`RB_H_VISIBLE)) &&
                       (v < raybox_pkg::scan_t'(`RB_V_VISIBLE));

    // Last pixel of line 478, well before the next frame starts
    assign o_load_point = (h == raybox_pkg::scan_t'(`RB_LOAD_H)) &&
                          (v == raybox_pkg::scan_t'(`RB_LOAD_V));

endmodule

// ==== spi_vector_rx.sv ====
/*
  SPI mode 0 receiver for the player position.
  A 48-bit frame, MSB first, carries playerX then playerY.
  Complete frames wait in a ready register and reach the
  position outputs at the next scan load point.
*/
`include "raybox_defs.svh"

module spi_vector_rx (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_sclk,
    input  logic               i_mosi,
    input  logic               i_ss_n,
    input  logic               i_load_point,
    output raybox_pkg::fixed_t o_player_x,
    output raybox_pkg::fixed_t o_player_y
);

    // Synchronisers
    // sclk and ss_n get a third stage for edge and level filtering
    logic [2:0] sclk_sync;
    logic [2:0] ss_sync;
    logic [1:0] mosi_sync;

    logic sclk_rise;
    logic ss_active;
    logic mosi;

    // Bit counter, 0..47
    logic [5:0] bit_count;
    logic       frame_end;

    // Earlier bits of the current frame, newest in bit 0
    logic [`RB_SPI_FRAME_BITS-2:0] spi_shift;
    logic [`RB_SPI_FRAME_BITS-1:0] spi_frame;

    raybox_pkg::fixed_t ready_x;
    raybox_pkg::fixed_t ready_y;
    raybox_pkg::fixed_t player_x;
    raybox_pkg::fixed_t player_y;

    always_ff @(posedge clk) begin
        if (reset) begin
            sclk_sync <= 3'b000;
            ss_sync   <= 3'b111;
            mosi_sync <= 2'b00;
        end else begin
            sclk_sync <= {sclk_sync[1:0], i_sclk};
            ss_sync   <= {ss_sync[1:0], i_ss_n};
            mosi_sync <= {mosi_sync[0], i_mosi};
        end
    end

    assign sclk_rise = (sclk_sync[2:1] == 2'b01);
    // Select counts only once both late stages agree it is low
    assign ss_active = ~ss_sync[2] & ~ss_sync[1];
    assign mosi      = mosi_sync[1];

    assign frame_end = (bit_count == 6'(`RB_SPI_FRAME_BITS - 1));
    // Full frame including the bit arriving this cycle
    assign spi_frame = {spi_shift, mosi};

    // Deselect throws away a partial frame
    always_ff @(posedge clk) begin
        if (reset || !ss_active) begin
            bit_count <= '0;
        end else if (sclk_rise) begin
            bit_count <= frame_end ? '0 : bit_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ss_active && sclk_rise) begin
            spi_shift <= spi_frame[`RB_SPI_FRAME_BITS-2:0];
        end
    end

    // Last bit in, so the frame goes straight to the ready register
    // A newer frame simply overwrites one still waiting
    always_ff @(posedge clk) begin
        if (reset) begin
            ready_x <= `RB_PLAYER_X_START;
            ready_y <= `RB_PLAYER_Y_START;
        end else if (ss_active && sclk_rise && frame_end) begin
            ready_x <= spi_frame[`RB_SPI_FRAME_BITS-1 -: `RB_QMN];
            ready_y <= spi_frame[`RB_QMN-1:0];
        end
    end

    // Reloaded every frame, even when no new SPI frame arrived
    always_ff @(posedge clk) begin
        if (reset) begin
            player_x <= `RB_PLAYER_X_START;
            player_y <= `RB_PLAYER_Y_START;
        end else if (i_load_point) begin
            player_x <= ready_x;
            player_y <= ready_y;
        end
    end

    assign o_player_x = player_x;
    assign o_player_y = player_y;

endmodule

// ==== pixel_composer.sv ====
/*
  Per-pixel colour for the current scan position.
  Draws the top-down map overlay with grid, player cell and player
  pixel over a ceiling and floor background, then registers the
  colours, blanks them outside the visible area and delays sync to match.
*/
`include "raybox_defs.svh"

module pixel_composer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_show_map,
    input  raybox_pkg::scan_t    i_scan_h,
    input  raybox_pkg::scan_t    i_scan_v,
    input  logic                 i_visible,
    input  logic                 i_hsync,
    input  logic                 i_vsync,
    input  raybox_pkg::fixed_t   i_player_x,
    input  raybox_pkg::fixed_t   i_player_y,
    output raybox_pkg::channel_t o_red,
    output raybox_pkg::channel_t o_green,
    output raybox_pkg::channel_t o_blue,
    output logic                 o_hsync,
    output logic                 o_vsync
);

    // Map cell under the scan position
    raybox_pkg::map_coord_t map_col;
    raybox_pkg::map_coord_t map_row;
    raybox_pkg::map_val_t   map_val;

    // Player cell and sub-cell offset
    raybox_pkg::map_coord_t player_col;
    raybox_pkg::map_coord_t player_row;
    logic [`RB_MAP_SCALE-1:0] player_off_x;
    logic [`RB_MAP_SCALE-1:0] player_off_y;

    logic in_map_overlay;
    logic in_map_gridline;
    logic in_player_cell;
    logic in_player_pixel;
    logic on_edge;
    logic on_pillar;

    raybox_pkg::channel_t background;
    raybox_pkg::channel_t map_r;
    raybox_pkg::channel_t map_g;
    raybox_pkg::channel_t map_b;
    raybox_pkg::channel_t r;
    raybox_pkg::channel_t g;
    raybox_pkg::channel_t b;

    assign map_col = i_scan_h[`RB_MAP_SCALE +: `RB_MAP_SIZE_BITS];
    assign map_row = i_scan_v[`RB_MAP_SCALE +: `RB_MAP_SIZE_BITS];

    // Fixed map in place of a ROM
    // Walls all round the border, single pillars on an 8-cell pitch
    assign on_edge   = (map_col == '0) || (map_col == '1) ||
                       (map_row == '0) || (map_row == '1);
    assign on_pillar = (map_col[2:0] == 3'd4) && (map_row[2:0] == 3'd4);

    always_comb begin
        if (on_edge) begin
            map_val = 2'd3;
        end else if (on_pillar) begin
            map_val = 2'd1;
        end else begin
            map_val = 2'd0;
        end
    end

    // Value 3 is white, 1 is blue, 0 is black
    assign map_r = {2{map_val[1]}};
    assign map_g = {2{&map_val}};
    assign map_b = {2{map_val[0]}};

    // Low integer bits pick the cell, top fraction bits the pixel in it
    assign player_col   = i_player_x[`RB_QN +: `RB_MAP_SIZE_BITS];
    assign player_row   = i_player_y[`RB_QN +: `RB_MAP_SIZE_BITS];
    assign player_off_x = i_player_x[`RB_QN-1 -: `RB_MAP_SCALE];
    assign player_off_y = i_player_y[`RB_QN-1 -: `RB_MAP_SCALE];

    assign in_map_overlay  = i_show_map &&
                             (i_scan_h < raybox_pkg::scan_t'(`RB_MAP_OVERLAY_SIZE)) &&
                             (i_scan_v < raybox_pkg::scan_t'(`RB_MAP_OVERLAY_SIZE));
    assign in_map_gridline = in_map_overlay &&
                             ((i_scan_h[`RB_MAP_SCALE-1:0] == '0) ||
                              (i_scan_v[`RB_MAP_SCALE-1:0] == '0));
    // Grid lines inside the player cell stay dark blue
    assign in_player_cell  = in_map_overlay && !in_map_gridline &&
                             (player_col == map_col) && (player_row == map_row);
    // Player pixel shows even where it falls on a grid line
    assign in_player_pixel = in_map_overlay &&
                             (player_col == map_col) && (player_row == map_row) &&
                             (player_off_x == i_scan_h[`RB_MAP_SCALE-1:0]) &&
                             (player_off_y == i_scan_v[`RB_MAP_SCALE-1:0]);

    // Dark grey ceiling, light grey floor
    assign background = (i_scan_v < raybox_pkg::scan_t'(`RB_HALF_HEIGHT)) ? 2'b01 : 2'b10;

    // Highest priority first
    always_comb begin
        if (in_player_pixel) begin
            // Yellow
            r = 2'b11;
            g = 2'b11;
            b = 2'b00;
        end else if (in_player_cell) begin
            // Dark green
            r = 2'b00;
            g = 2'b01;
            b = 2'b00;
        end else if (in_map_gridline) begin
            // Dark blue
            r = 2'b00;
            g = 2'b00;
            b = 2'b01;
        end else if (in_map_overlay) begin
            r = map_r;
            g = map_g;
            b = map_b;
        end else begin
            r = background;
            g = background;
            b = background;
        end
    end

    // One register stage, sync delayed alongside so both stay aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            o_red   <= '0;
            o_green <= '0;
            o_blue  <= '0;
            o_hsync <= 1'b1;
            o_vsync <= 1'b1;
        end else begin
            o_red   <= i_visible ? r : 2'b00;
            o_green <= i_visible ? g : 2'b00;
            o_blue  <= i_visible ? b : 2'b00;
            o_hsync <= i_hsync;
            o_vsync <= i_vsync;
        end
    end

endmodule

// ==== raybox_top.sv ====
/*
  Raybox display top level.
  Scan timer and SPI position receiver run side by side and feed
  the pixel composer, which drives the VGA pins.
*/

module raybox_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_show_map,
    input  logic                 i_sclk,
    input  logic                 i_mosi,
    input  logic                 i_ss_n,
    output raybox_pkg::channel_t o_red,
    output raybox_pkg::channel_t o_green,
    output raybox_pkg::channel_t o_blue,
    output logic                 o_hsync,
    output logic                 o_vsync
);

    // Scan position and raw sync from the timer
    raybox_pkg::scan_t  scan_h;
    raybox_pkg::scan_t  scan_v;
    logic               hsync;
    logic               vsync;
    logic               visible;
    logic               load_point;

    // Position held for the current frame
    raybox_pkg::fixed_t player_x;
    raybox_pkg::fixed_t player_y;

    vga_timing u_vga_timing (
        .clk          (clk),
        .reset        (reset),
        .o_scan_h     (scan_h),
        .o_scan_v     (scan_v),
        .o_hsync      (hsync),
        .o_vsync      (vsync),
        .o_visible    (visible),
        .o_load_point (load_point)
    );

    spi_vector_rx u_spi_vector_rx (
        .clk          (clk),
        .reset        (reset),
        .i_sclk       (i_sclk),
        .i_mosi       (i_mosi),
        .i_ss_n       (i_ss_n),
        .i_load_point (load_point),
        .o_player_x   (player_x),
        .o_player_y   (player_y)
    );

    pixel_composer u_pixel_composer (
        .clk          (clk),
        .reset        (reset),
        .i_show_map   (i_show_map),
        .i_scan_h     (scan_h),
        .i_scan_v     (scan_v),
        .i_visible    (visible),
        .i_hsync      (hsync),
        .i_vsync      (vsync),
        .i_player_x   (player_x),
        .i_player_y   (player_y),
        .o_red        (o_red),
        .o_green      (o_green),
        .o_blue       (o_blue),
        .o_hsync      (o_hsync),
        .o_vsync      (o_vsync)
    );

endmodule

// ==== tb_raybox_sva.sv ====
/*
  Concurrent checks on raybox_top, attached with bind.
  Blanking during sync, hsync pulse width and the one cycle
  in each frame where the player position may change.
*/
`include "raybox_defs.svh"

module tb_raybox_sva (
    input logic                 clk,
    input logic                 reset,
    input raybox_pkg::channel_t i_red,
    input raybox_pkg::channel_t i_green,
    input raybox_pkg::channel_t i_blue,
    input logic                 i_hsync,
    input logic                 i_vsync,
    input logic                 i_load_point,
    input raybox_pkg::fixed_t   i_player_x,
    input raybox_pkg::fixed_t   i_player_y
);
    timeunit 1ns;
    timeprecision 1ps;

    // Length of the current low run on hsync
    int hs_low_count;

    always_ff @(posedge clk) begin
        if (reset || i_hsync) begin
            hs_low_count <= 0;
        end else begin
            hs_low_count <= hs_low_count + 1;
        end
    end

    // No colour while either sync pulse is active
    a_sync_blank: assert property (@(posedge clk) disable iff (reset)
        (!i_hsync || !i_vsync) |-> (i_red == 2'b00 && i_green == 2'b00 && i_blue == 2'b00))
        else $error("colour driven during a sync pulse");

    // Pulse ends after exactly 96 low clocks
    a_hsync_width: assert property (@(posedge clk) disable iff (reset)
        $rose(i_hsync) |-> (hs_low_count == `RB_H_SYNC_END - `RB_H_SYNC_START))
        else $error("hsync pulse lasted %0d clocks", hs_low_count);

    // Position register moves only right after the load point
    a_load_only: assert property (@(posedge clk) disable iff (reset)
        ($changed(i_player_x) || $changed(i_player_y)) |-> $past(i_load_point))
        else $error("player position changed outside the load point");

endmodule

bind raybox_top tb_raybox_sva u_sva (
    .clk          (clk),
    .reset        (reset),
    .i_red        (o_red),
    .i_green      (o_green),
    .i_blue       (o_blue),
    .i_hsync      (o_hsync),
    .i_vsync      (o_vsync),
    .i_load_point (load_point),
    .i_player_x   (player_x),
    .i_player_y   (player_y)
);

// ==== tb_raybox.sv ====
/*
  Testbench for raybox_top.
  Applies a table of tests: each sets the map overlay, optionally sends
  an SPI position and probes chosen output pixels. Every cycle is also
  checked for sync levels and for blanking outside the visible area.
*/
`include "raybox_defs.svh"

module tb_raybox;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NO_SPI       = 0;
    localparam int FULL_SPI     = 1;
    localparam int CUT_SPI      = 2;
    localparam int CUT_BITS     = 20;
    localparam int HALF_BIT     = 5;
    localparam int FRAME_CYCLES = `RB_H_TOTAL * `RB_V_TOTAL;

    typedef struct {
        logic               show_map;
        int                 spi_mode;
        raybox_pkg::fixed_t x;
        raybox_pkg::fixed_t y;
    } row_t;

    typedef struct {
        int                   test;
        int                   h;
        int                   v;
        raybox_pkg::channel_t r;
        raybox_pkg::channel_t g;
        raybox_pkg::channel_t b;
    } probe_t;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 show_map;
    logic                 sclk;
    logic                 mosi;
    logic                 ss_n;
    raybox_pkg::channel_t red;
    raybox_pkg::channel_t green;
    raybox_pkg::channel_t blue;
    logic                 hsync;
    logic                 vsync;

    // Pixel now shown at the outputs, one clock behind the DUT counters
    int   oh;
    int   ov;
    logic scan_run;

    row_t   rows[$];
    probe_t probes[$];
    int     checks = 0;
    int     errors = 0;
    int     cycles = 0;
    int     timeout_limit;
    // Cycles since the last falling edge of each sync output
    int     hs_gap = 0;
    int     vs_gap = 0;
    logic   hs_prev = 1'b1;
    logic   vs_prev = 1'b1;

    raybox_top UUT (
        .clk        (clk),
        .reset      (reset),
        .i_show_map (show_map),
        .i_sclk     (sclk),
        .i_mosi     (mosi),
        .i_ss_n     (ss_n),
        .o_red      (red),
        .o_green    (green),
        .o_blue     (blue),
        .o_hsync    (hsync),
        .o_vsync    (vsync)
    );

    always #5 clk = ~clk;

    // Output scan position, reaches (0,0) at the first edge out of reset
    always @(posedge clk) begin
        if (reset) begin
            oh <= `RB_H_TOTAL - 1;
            ov <= `RB_V_TOTAL - 1;
        end else if (oh == `RB_H_TOTAL - 1) begin
            oh <= 0;
            ov <= (ov == `RB_V_TOTAL - 1) ? 0 : ov + 1;
        end else begin
            oh <= oh + 1;
        end
        scan_run <= !reset;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_channel(input string chan, input raybox_pkg::channel_t got,
                                 input raybox_pkg::channel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s at pixel (%0d,%0d) is %b, expected %b",
                     $time, chan, oh, ov, got, exp);
        end
    endtask

    task automatic check_sync(input logic got_h, input logic got_v,
                              input logic exp_h, input logic exp_v);
        checks++;
        if (got_h !== exp_h || got_v !== exp_v) begin
            errors++;
            $display("Fail %0t: sync at pixel (%0d,%0d) is h=%b v=%b, expected h=%b v=%b",
                     $time, oh, ov, got_h, got_v, exp_h, exp_v);
        end
    endtask

    // One clock, then the checks that hold on every pixel
    task automatic step();
        @(negedge clk);
        if (scan_run) begin
            check_sync(hsync, vsync,
                       !(oh >= `RB_H_SYNC_START && oh < `RB_H_SYNC_END),
                       !(ov >= `RB_V_SYNC_START && ov < `RB_V_SYNC_END));
            if (oh >= `RB_H_VISIBLE || ov >= `RB_V_VISIBLE) begin
                check_channel("red", red, 2'b00);
                check_channel("green", green, 2'b00);
                check_channel("blue", blue, 2'b00);
            end
            hs_gap = (hs_prev && !hsync) ? 0 : hs_gap + 1;
            vs_gap = (vs_prev && !vsync) ? 0 : vs_gap + 1;
            hs_prev = hsync;
            vs_prev = vsync;
            if (hs_gap == `RB_H_TOTAL) begin
                errors++;
                $display("Error at %0t: hsync has not fallen for a whole line", $time);
            end
            if (vs_gap == FRAME_CYCLES) begin
                errors++;
                $display("Error at %0t: vsync has not fallen for a whole frame", $time);
            end
        end
    endtask

    task automatic wait_pixel(input int h, input int v);
        step();
        while (!(oh == h && ov == v)) begin
            step();
        end
    endtask

    // Mode 0, MSB first, each sclk level held for HALF_BIT clocks
    task automatic send_spi(input raybox_pkg::fixed_t x, input raybox_pkg::fixed_t y,
                            input int nbits);
        logic [`RB_SPI_FRAME_BITS-1:0] frame;
        int i;
        frame = {x, y};
        ss_n = 1'b0;
        for (i = 0; i < nbits; i++) begin
            mosi = frame[`RB_SPI_FRAME_BITS - 1 - i];
            repeat (HALF_BIT) step();
            sclk = 1'b1;
            repeat (HALF_BIT) step();
            sclk = 1'b0;
        end
        repeat (HALF_BIT) step();
        ss_n = 1'b1;
        repeat (HALF_BIT) step();
    endtask

    task automatic add_row(input logic map_on, input int mode,
                           input raybox_pkg::fixed_t x, input raybox_pkg::fixed_t y);
        row_t row;
        row.show_map = map_on;
        row.spi_mode = mode;
        row.x = x;
        row.y = y;
        rows.push_back(row);
    endtask

    // Probes of one test must be added in scan order
    task automatic add_probe(input int test, input int h, input int v,
                             input raybox_pkg::channel_t r, input raybox_pkg::channel_t g,
                             input raybox_pkg::channel_t b);
        probe_t pr;
        pr.test = test;
        pr.h = h;
        pr.v = v;
        pr.r = r;
        pr.g = g;
        pr.b = b;
        probes.push_back(pr);
    endtask

    task automatic build_tests();
        int t;
        int cx;
        int cy;
        int ox;
        int oy;
        raybox_pkg::fixed_t x;
        raybox_pkg::fixed_t y;
        // Start position 32.5, 39.5 is pixel (130,158) in cell (32,39)
        add_row(1'b1, NO_SPI, '0, '0);
        add_probe(0, 130, 156, 2'b00, 2'b00, 2'b01);
        add_probe(0, 129, 157, 2'b00, 2'b01, 2'b00);
        add_probe(0, 128, 158, 2'b00, 2'b00, 2'b01);
        add_probe(0, 130, 158, 2'b11, 2'b11, 2'b00);
        add_probe(0, 131, 159, 2'b00, 2'b01, 2'b00);
        // Edge walls, pillar at (4,4), empty (5,5), grid and overlay border
        add_row(1'b1, NO_SPI, '0, '0);
        add_probe(1, 1, 1, 2'b11, 2'b11, 2'b11);
        add_probe(1, 17, 17, 2'b00, 2'b00, 2'b11);
        add_probe(1, 21, 21, 2'b00, 2'b00, 2'b00);
        add_probe(1, 20, 22, 2'b00, 2'b00, 2'b01);
        add_probe(1, 253, 41, 2'b11, 2'b11, 2'b11);
        add_probe(1, 256, 101, 2'b00, 2'b00, 2'b01);
        add_probe(1, 257, 101, 2'b01, 2'b01, 2'b01);
        // Ceiling and floor only, blanked outside the visible area
        add_row(1'b0, NO_SPI, '0, '0);
        add_probe(2, 640, 10, 2'b00, 2'b00, 2'b00);
        add_probe(2, 130, 158, 2'b01, 2'b01, 2'b01);
        add_probe(2, 10, 239, 2'b01, 2'b01, 2'b01);
        add_probe(2, 10, 240, 2'b10, 2'b10, 2'b10);
        add_probe(2, 639, 479, 2'b10, 2'b10, 2'b10);
        add_probe(2, 5, 480, 2'b00, 2'b00, 2'b00);
        add_probe(2, 700, 500, 2'b00, 2'b00, 2'b00);
        // 10.25, 20.75 gives pixel (41,83); old spot is plain floor now
        add_row(1'b1, FULL_SPI, 24'h00A400, 24'h014C00);
        add_probe(3, 41, 83, 2'b11, 2'b11, 2'b00);
        add_probe(3, 42, 83, 2'b00, 2'b01, 2'b00);
        add_probe(3, 130, 158, 2'b00, 2'b00, 2'b00);
        // Frame towards 50.0, 50.0 is cut short so nothing moves
        add_row(1'b1, CUT_SPI, 24'h032000, 24'h032000);
        add_probe(4, 41, 83, 2'b11, 2'b11, 2'b00);
        add_probe(4, 200, 200, 2'b00, 2'b00, 2'b01);
        // Random cells 1..62 with random upper integer and lower fraction bits
        for (t = 5; t < 8; t++) begin
            cx = 1 + int'($urandom % 62);
            cy = 1 + int'($urandom % 62);
            ox = int'($urandom % 4);
            oy = int'($urandom % 4);
            x = {6'($urandom), 6'(cx), 2'(ox), 10'($urandom)};
            y = {6'($urandom), 6'(cy), 2'(oy), 10'($urandom)};
            add_row(1'b1, FULL_SPI, x, y);
            add_probe(t, 4 * cx + ox, 4 * cy + oy, 2'b11, 2'b11, 2'b00);
            // Last pixel of the player cell, after the player pixel in scan order
            if (ox != 3 || oy != 3) begin
                add_probe(t, 4 * cx + 3, 4 * cy + 3, 2'b00, 2'b01, 2'b00);
            end
        end
    endtask

    initial begin
        int t;
        int p;
        int chk0;
        int err0;
        reset = 1'b1;
        show_map = 1'b0;
        sclk = 1'b0;
        mosi = 1'b0;
        ss_n = 1'b1;
        void'($urandom(32'he3cad960));
        build_tests();
        timeout_limit = rows.size() * 2 * FRAME_CYCLES * 11 / 10;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (t = 0; t < rows.size(); t++) begin
            chk0 = checks;
            err0 = errors;
            show_map = rows[t].show_map;
            wait_pixel(0, 0);
            // Position sent in frame N shows up from frame N+1
            if (rows[t].spi_mode != NO_SPI) begin
                send_spi(rows[t].x, rows[t].y,
                         (rows[t].spi_mode == FULL_SPI) ? `RB_SPI_FRAME_BITS : CUT_BITS);
                wait_pixel(0, 0);
            end
            for (p = 0; p < probes.size(); p++) begin
                if (probes[p].test == t) begin
                    wait_pixel(probes[p].h, probes[p].v);
                    check_channel("red", red, probes[p].r);
                    check_channel("green", green, probes[p].g);
                    check_channel("blue", blue, probes[p].b);
                end
            end
            $display("Test %0d done: %0d checks, %0d errors", t, checks - chk0, errors - err0);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
raybox_pkg.sv
vga_timing.sv
spi_vector_rx.sv
pixel_composer.sv
raybox_top.sv
tb_raybox_sva.sv
tb_raybox.sv

// ==== Makefile ====
# Verilator simulation of the raybox display pipeline
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_raybox
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail if the log reports errors"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "Simulation did not complete"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
